/* logic/l2CachePkg.sv */
// L2 tag and coherence-state cache, shared definitions
// Sizes, address field types, MESI and command encodings, bus structs
`default_nettype none

package l2CachePkg;

  //****************************************
  // Sizes
  //****************************************
  localparam int AddrWidth   = 32;
  localparam int ByteSelBits = 6;   // 64-byte line
  localparam int IndexBits   = 4;
  localparam int NumSets     = 2 ** IndexBits;
  localparam int NumWays     = 4;
  localparam int TagBits     = AddrWidth - IndexBits - ByteSelBits;

  typedef logic [TagBits-1:0]   tag_t;
  typedef logic [IndexBits-1:0] index_t;
  typedef logic [1:0]           wayIdx_t;
  typedef logic [1:0]           age_t;     // 0 is most recently used
  typedef logic [31:0]          count_t;

  //****************************************
  // Encodings
  //****************************************
  typedef enum logic [1:0] {Modified, Exclusive, Shared, Invalid} mesi_t;

  // Code 5 has no command and is rejected as unknown
  typedef enum logic [2:0] {
    L1Read     = 3'd0,
    L1InstRead = 3'd2,
    L1Write    = 3'd1,
    SnoopRead  = 3'd4,
    SnoopInval = 3'd3,
    SnoopRfo   = 3'd6,
    Clear      = 3'd7
  } cmdOp_t;

  typedef enum logic [1:0] {BusNone, BusRead, BusRfo, BusInval} busOp_t;

  typedef enum logic [1:0] {
    SnoopMiss = 2'b00,
    SnoopHit  = 2'b01,
    SnoopHitM = 2'b10
  } snoop_t;

  //****************************************
  // Structs
  //****************************************
  typedef struct packed {
    cmdOp_t op;
    snoop_t snoopIn;   // Other caches' answer, used on L1 misses
  } cacheReq_t;

  typedef struct packed {
    tag_t  tag;
    mesi_t state;
    age_t  age;
  } lineState_t;

  typedef struct packed {
    logic    hit;
    wayIdx_t way;
    mesi_t   newState;
    busOp_t  busOp;
    snoop_t  snoopOut;
  } cacheResp_t;

  typedef struct packed {
    lineState_t [NumWays-1:0] line;
  } setView_t;

  // Only L1 commands touch LRU and the statistics
  function automatic logic isL1Op(input cmdOp_t op);
    return op inside {L1Read, L1InstRead, L1Write};
  endfunction

endpackage

`default_nettype wire

/* logic/tagStore.sv */
// Tag, MESI state and LRU age storage
// One whole set per entry, registered read port and whole-set write port
`timescale 1ns/1ps
`default_nettype none

module tagStore (
  input  logic                  clk,
  input  logic                  readEn,
  input  l2CachePkg::index_t    readIndex,
  input  logic                  writeEn,
  input  logic                  clearEn,
  input  l2CachePkg::index_t    writeIndex,
  input  l2CachePkg::setView_t  writeSet,
  output l2CachePkg::setView_t  curSet
);
  import l2CachePkg::*;

  setView_t sets [NumSets];
  setView_t clearSet;

  // Empty set with distinct ages, way n gets age n
  always_comb begin
    for (int w = 0; w < NumWays; w++) begin
      clearSet.line[w].tag   = '0;
      clearSet.line[w].state = Invalid;
      clearSet.line[w].age   = age_t'(w);
    end
  end

  //****************************************
  // Write port
  //****************************************
  always_ff @(posedge clk) begin
    if (clearEn) begin
      sets[writeIndex] <= clearSet;  // Sweep pattern wins over a write-back
    end else if (writeEn) begin
      sets[writeIndex] <= writeSet;
    end
  end

  //****************************************
  // Read port
  //****************************************
  always_ff @(posedge clk) begin
    if (readEn) begin
      curSet <= sets[readIndex];  // Held until the next read
    end
  end

endmodule

`default_nettype wire

/* logic/wayLookup.sv */
// Way lookup for one set
// Tag compare per way, hit encoder, victim choice and LRU ageing
`timescale 1ns/1ps
`default_nettype none

module wayLookup (
  input  l2CachePkg::setView_t  curSet,
  input  l2CachePkg::tag_t      reqTag,
  input  logic                  touch,
  output logic                  hit,
  output l2CachePkg::wayIdx_t   hitWay,
  output l2CachePkg::wayIdx_t   victimWay,
  output l2CachePkg::setView_t  agedSet
);
  import l2CachePkg::*;

  logic [NumWays-1:0] match;
  logic               foundFree;
  age_t               oldestAge;
  wayIdx_t            usedWay;
  age_t               usedAge;

  // Valid line with the same tag
  always_comb begin
    for (int w = 0; w < NumWays; w++) begin
      match[w] = (curSet.line[w].state != Invalid) && (curSet.line[w].tag == reqTag);
    end
  end

  always_comb begin
    hit    = |match;
    hitWay = '0;
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (match[w]) hitWay = wayIdx_t'(w);  // Lowest match wins
    end
  end

  //****************************************
  // Victim choice
  //****************************************
  always_comb begin
    foundFree = 1'b0;
    victimWay = '0;
    oldestAge = curSet.line[0].age;
    for (int w = 0; w < NumWays; w++) begin
      if (!foundFree && curSet.line[w].state == Invalid) begin
        foundFree = 1'b1;
        victimWay = wayIdx_t'(w);
      end
    end
    if (!foundFree) begin
      for (int w = 1; w < NumWays; w++) begin
        // Strictly older only, so a tie keeps the lower way
        if (curSet.line[w].age > oldestAge) begin
          oldestAge = curSet.line[w].age;
          victimWay = wayIdx_t'(w);
        end
      end
    end
  end

  //****************************************
  // LRU ageing
  //****************************************
  assign usedWay = hit ? hitWay : victimWay;
  assign usedAge = curSet.line[usedWay].age;

  always_comb begin
    agedSet = curSet;
    if (touch) begin
      for (int w = 0; w < NumWays; w++) begin
        if (curSet.line[w].age < usedAge) begin
          agedSet.line[w].age = curSet.line[w].age + 1'b1;
        end
      end
      agedSet.line[usedWay].age = '0;  // Most recently used
    end
  end

endmodule

`default_nettype wire

/* logic/mesiPolicy.sv */
// MESI policy
// Next line state, bus operation and snoop answer for each command,
// and the updated set that goes back to the tag store
`timescale 1ns/1ps
`default_nettype none

module mesiPolicy (
  input  l2CachePkg::cacheReq_t   req,
  input  l2CachePkg::tag_t        reqTag,
  input  logic                    hit,
  input  l2CachePkg::wayIdx_t     hitWay,
  input  l2CachePkg::wayIdx_t     victimWay,
  input  l2CachePkg::setView_t    agedSet,
  output l2CachePkg::setView_t    nextSet,
  output l2CachePkg::cacheResp_t  policyResp
);
  import l2CachePkg::*;

  wayIdx_t useWay;
  mesi_t   oldState;   // Meaningful only on a hit
  mesi_t   newState;
  busOp_t  busOp;
  snoop_t  snoopOut;

  assign useWay   = hit ? hitWay : victimWay;
  assign oldState = agedSet.line[hitWay].state;

  //****************************************
  // Transitions
  //****************************************
  always_comb begin
    newState = hit ? oldState : Invalid;
    busOp    = BusNone;
    snoopOut = SnoopMiss;
    case (req.op)
      L1Read, L1InstRead: begin
        if (!hit) begin
          // Fill from the bus, shared if anyone else holds it
          newState = (req.snoopIn == SnoopMiss) ? Exclusive : Shared;
          busOp    = BusRead;
        end
      end
      L1Write: begin
        if (!hit) begin
          newState = Modified;
          busOp    = BusRfo;
        end else if (oldState != Modified) begin
          newState = Modified;
          busOp    = BusInval;  // Upgrade, other copies must go
        end
      end
      SnoopRead: begin
        if (hit) begin
          newState = Shared;
          snoopOut = (oldState == Modified) ? SnoopHitM : SnoopHit;
        end
      end
      SnoopInval: begin
        if (hit) begin
          newState = Invalid;
          snoopOut = (oldState == Modified) ? SnoopHitM : SnoopMiss;
        end
      end
      SnoopRfo: begin
        if (hit) begin
          newState = Invalid;
          snoopOut = (oldState == Modified) ? SnoopHitM : SnoopHit;
        end
      end
      default: ;  // Clear and unknown codes change nothing here
    endcase
  end

  // L1 misses fill the victim, snoop misses leave the set as it was
  always_comb begin
    nextSet = agedSet;
    if (hit || isL1Op(req.op)) begin
      nextSet.line[useWay].tag   = reqTag;
      nextSet.line[useWay].state = newState;
    end
  end

  assign policyResp = '{hit: hit, way: useWay, newState: newState, busOp: busOp,
                        snoopOut: snoopOut};

endmodule

`default_nettype wire

/* logic/statCounters.sv */
// Statistics counters
// Hits, misses, reads and writes of L1 commands, one selected for APB reads
`timescale 1ns/1ps
`default_nettype none

module statCounters (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   countEn,
  input  l2CachePkg::cacheReq_t  req,
  input  logic                   hit,
  input  logic [1:0]             countSel,
  output l2CachePkg::count_t     countData
);
  import l2CachePkg::*;

  count_t hitCnt;
  count_t missCnt;
  count_t readCnt;
  count_t writeCnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      hitCnt   <= '0;
      missCnt  <= '0;
      readCnt  <= '0;
      writeCnt <= '0;
    end else if (countEn && isL1Op(req.op)) begin
      if (hit) hitCnt <= hitCnt + 1'b1;
      else     missCnt <= missCnt + 1'b1;
      if (req.op == L1Write) writeCnt <= writeCnt + 1'b1;
      else                   readCnt <= readCnt + 1'b1;  // Data and instruction reads
    end
  end

  always_comb begin
    case (countSel)
      2'd0:    countData = hitCnt;
      2'd1:    countData = missCnt;
      2'd2:    countData = readCnt;
      default: countData = writeCnt;
    endcase
  end

endmodule

`default_nettype wire

/* logic/apbCmdPort.sv */
// APB slave and command sequencer
// Captures one command per write transfer, steps it through read, write-back
// and response, and runs the clear sweep after reset and on Clear
`timescale 1ns/1ps
`default_nettype none

module apbCmdPort (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               psel,
  input  logic                               penable,
  input  logic                               pwrite,
  input  logic [l2CachePkg::AddrWidth-1:0]   paddr,
  input  logic [31:0]                        pwdata,
  input  l2CachePkg::setView_t               nextSet,
  input  l2CachePkg::cacheResp_t             policyResp,
  input  l2CachePkg::count_t                 countData,
  output logic                               pready,
  output logic [31:0]                        prdata,
  output logic                               pslverr,
  output l2CachePkg::cacheResp_t             resp,
  output logic                               respValid,
  output logic                               readEn,
  output l2CachePkg::index_t                 readIndex,
  output logic                               writeEn,
  output l2CachePkg::index_t                 writeIndex,
  output l2CachePkg::setView_t               writeSet,
  output logic                               clearEn,
  output l2CachePkg::tag_t                   reqTag,
  output l2CachePkg::cacheReq_t              req,
  output logic                               touch,
  output logic                               countEn,
  output logic [1:0]                         countSel
);
  import l2CachePkg::*;

  typedef enum logic [1:0] {Clearing, Idle, Lookup, Update} portState_t;

  portState_t state;
  index_t     sweepIdx;    // Set being cleared
  logic       sweepIsCmd;  // Sweep started by Clear, not by reset
  index_t     reqIndex;
  logic       opValid;
  logic       setupWr;
  logic       setupRd;
  logic       sweepLast;
  cacheReq_t  busReq;

  assign setupWr   = psel && !penable && pwrite;
  assign setupRd   = psel && !penable && !pwrite;
  assign sweepLast = (sweepIdx == index_t'(NumSets - 1));
  assign busReq    = cacheReq_t'(pwdata[$bits(cacheReq_t)-1:0]);

  //****************************************
  // Command FSM
  //****************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= Clearing;
      sweepIdx   <= '0;
      sweepIsCmd <= 1'b0;
      pready     <= 1'b0;
      pslverr    <= 1'b0;
      respValid  <= 1'b0;
    end else begin
      pready    <= 1'b0;  // Single-cycle strobes
      pslverr   <= 1'b0;
      respValid <= 1'b0;
      case (state)
        Clearing: begin
          sweepIdx <= sweepIdx + 1'b1;  // Wraps back to 0 after the last set
          if (sweepLast) begin
            state     <= Idle;
            pready    <= sweepIsCmd;  // Reset sweep has no transfer to end
            respValid <= sweepIsCmd;
          end
        end
        Idle: begin
          if (setupWr) begin
            if (busReq.op == Clear) begin
              state      <= Clearing;
              sweepIsCmd <= 1'b1;
            end else begin
              state <= Lookup;
            end
          end else if (setupRd) begin
            pready <= 1'b1;  // Counter comes back in the first access cycle
          end
        end
        Lookup: state <= Update;  // Set read in flight
        Update: begin
          state     <= Idle;
          pready    <= 1'b1;
          respValid <= 1'b1;
          pslverr   <= !opValid;
        end
        default: state <= Idle;
      endcase
    end
  end

  // Request capture, address split into tag and index
  // Low ByteSelBits only pick a byte inside the line
  always_ff @(posedge clk) begin
    if (state == Idle && setupWr) begin
      req      <= busReq;
      reqTag   <= paddr[AddrWidth-1 -: TagBits];
      reqIndex <= paddr[ByteSelBits +: IndexBits];
      opValid  <= busReq.op inside {L1Read, L1InstRead, L1Write, SnoopRead,
                                    SnoopInval, SnoopRfo, Clear};
    end
    if (state == Idle && setupRd) begin
      prdata <= countData;
    end
    if (state == Update) begin
      resp <= policyResp;
    end else if (state == Clearing && sweepLast) begin
      resp <= '{hit: 1'b0, way: '0, newState: Invalid, busOp: BusNone,
                snoopOut: SnoopMiss};
    end
  end

  assign readEn     = (state == Lookup);
  assign readIndex  = reqIndex;
  assign writeEn    = (state == Update) && opValid;  // Unknown op leaves the set alone
  assign writeIndex = (state == Clearing) ? sweepIdx : reqIndex;
  assign writeSet   = nextSet;
  assign clearEn    = (state == Clearing);
  assign touch      = isL1Op(req.op);
  assign countEn    = (state == Update) && opValid;
  assign countSel   = paddr[3:2];  // 0 hits, 1 misses, 2 reads, 3 writes

endmodule

`default_nettype wire

/* logic/l2Cache.sv */
// L2 cache top level
// APB command port around the tag store, way lookup, MESI policy and counters
`timescale 1ns/1ps
`default_nettype none

module l2Cache (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               psel,
  input  logic                               penable,
  input  logic                               pwrite,
  input  logic [l2CachePkg::AddrWidth-1:0]   paddr,
  input  logic [31:0]                        pwdata,
  output logic                               pready,
  output logic [31:0]                        prdata,
  output logic                               pslverr,
  output l2CachePkg::cacheResp_t             resp,
  output logic                               respValid
);
  import l2CachePkg::*;

  logic       readEn;
  index_t     readIndex;
  logic       writeEn;
  index_t     writeIndex;
  setView_t   writeSet;
  logic       clearEn;
  setView_t   curSet;
  tag_t       reqTag;
  cacheReq_t  req;
  logic       touch;
  logic       countEn;
  logic [1:0] countSel;
  count_t     countData;
  logic       hit;
  wayIdx_t    hitWay;
  wayIdx_t    victimWay;
  setView_t   agedSet;
  setView_t   nextSet;
  cacheResp_t policyResp;

  apbCmdPort i_apbCmdPort (
    .clk        (clk),
    .rst        (rst),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .nextSet    (nextSet),
    .policyResp (policyResp),
    .countData  (countData),
    .pready     (pready),
    .prdata     (prdata),
    .pslverr    (pslverr),
    .resp       (resp),
    .respValid  (respValid),
    .readEn     (readEn),
    .readIndex  (readIndex),
    .writeEn    (writeEn),
    .writeIndex (writeIndex),
    .writeSet   (writeSet),
    .clearEn    (clearEn),
    .reqTag     (reqTag),
    .req        (req),
    .touch      (touch),
    .countEn    (countEn),
    .countSel   (countSel)
  );

  tagStore i_tagStore (
    .clk        (clk),
    .readEn     (readEn),
    .readIndex  (readIndex),
    .writeEn    (writeEn),
    .clearEn    (clearEn),
    .writeIndex (writeIndex),
    .writeSet   (writeSet),
    .curSet     (curSet)
  );

  wayLookup i_wayLookup (
    .curSet    (curSet),
    .reqTag    (reqTag),
    .touch     (touch),
    .hit       (hit),
    .hitWay    (hitWay),
    .victimWay (victimWay),
    .agedSet   (agedSet)
  );

  mesiPolicy i_mesiPolicy (
    .req        (req),
    .reqTag     (reqTag),
    .hit        (hit),
    .hitWay     (hitWay),
    .victimWay  (victimWay),
    .agedSet    (agedSet),
    .nextSet    (nextSet),
    .policyResp (policyResp)
  );

  statCounters i_statCounters (
    .clk       (clk),
    .rst       (rst),
    .countEn   (countEn),
    .req       (req),
    .hit       (hit),
    .countSel  (countSel),
    .countData (countData)
  );

endmodule

`default_nettype wire

/* tb/cacheModel.svh */
// Reference model of the L2 cache
// Tags, MESI states, LRU ages and statistics, advanced one command at a time
`ifndef CACHE_MODEL_SVH
`define CACHE_MODEL_SVH

tag_t  refTag   [NumSets][NumWays];
mesi_t refState [NumSets][NumWays];
int    refAge   [NumSets][NumWays];
int    refHits;
int    refMisses;
int    refReads;
int    refWrites;

// Empty cache, way n starts at age n
function automatic void resetModel();
  for (int s = 0; s < NumSets; s++) begin
    for (int w = 0; w < NumWays; w++) begin
      refTag[s][w]   = '0;
      refState[s][w] = Invalid;
      refAge[s][w]   = w;
    end
  end
endfunction

// Expected response of one command, the model moves to the new state
function automatic cacheResp_t predictAccess(input cmdOp_t op, input snoop_t snoopIn,
                                             input tag_t tag, input index_t idx);
  cacheResp_t r;
  int         found;
  int         victim;
  int         used;
  int         usedAge;
  mesi_t      cur;
  logic       isL1;
  found  = -1;
  victim = -1;
  isL1   = op inside {L1Read, L1InstRead, L1Write};
  for (int w = NumWays - 1; w >= 0; w--) begin
    if (refState[idx][w] != Invalid && refTag[idx][w] == tag) found = w;
    if (refState[idx][w] == Invalid) victim = w;  // Lowest free way
  end
  if (victim < 0) begin
    victim = 0;
    for (int w = 1; w < NumWays; w++) begin
      if (refAge[idx][w] > refAge[idx][victim]) victim = w;
    end
  end
  used       = (found >= 0) ? found : victim;
  cur        = refState[idx][used];
  r.hit      = (found >= 0);
  r.way      = wayIdx_t'(used);
  r.newState = r.hit ? cur : Invalid;
  r.busOp    = BusNone;
  r.snoopOut = SnoopMiss;
  case (op)
    L1Read, L1InstRead: begin
      if (!r.hit) begin
        r.newState = (snoopIn == SnoopMiss) ? Exclusive : Shared;
        r.busOp    = BusRead;
      end
    end
    L1Write: begin
      r.newState = Modified;
      if (!r.hit) r.busOp = BusRfo;
      else if (cur != Modified) r.busOp = BusInval;
    end
    SnoopRead: begin
      if (r.hit) begin
        r.newState = Shared;
        r.snoopOut = (cur == Modified) ? SnoopHitM : SnoopHit;
      end
    end
    SnoopInval: begin
      if (r.hit) begin
        r.newState = Invalid;
        r.snoopOut = (cur == Modified) ? SnoopHitM : SnoopMiss;
      end
    end
    default: begin  // Snooped RFO
      if (r.hit) begin
        r.newState = Invalid;
        r.snoopOut = (cur == Modified) ? SnoopHitM : SnoopHit;
      end
    end
  endcase
  if (isL1) begin
    usedAge = refAge[idx][used];
    for (int w = 0; w < NumWays; w++) begin
      if (refAge[idx][w] < usedAge) refAge[idx][w]++;
    end
    refAge[idx][used]   = 0;
    refTag[idx][used]   = tag;
    refState[idx][used] = r.newState;
    if (r.hit) refHits++;
    else refMisses++;
    if (op == L1Write) refWrites++;
    else refReads++;
  end else if (r.hit) begin
    refState[idx][used] = r.newState;  // Snoops never move LRU
  end
  return r;
endfunction

`endif

/* tb/l2CacheTb.sv */
// Testbench for the L2 tag and coherence-state cache
// Drives APB commands and counter reads, checks against a reference model
`timescale 1ns/1ps
`default_nettype none

module l2CacheTb;
  import l2CachePkg::*;

  localparam int TimeoutCycles = 100;

  logic        clk;
  logic        rst;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] paddr;
  logic [31:0] pwdata;
  logic        pready;
  logic [31:0] prdata;
  logic        pslverr;
  cacheResp_t  resp;
  logic        respValid;
  int          errors;
  int          checks;
  int          timeouts;
  index_t      baseIdx;
  tag_t        keepTag;

  `include "cacheModel.svh"

  l2Cache i_l2Cache (
    .clk       (clk),
    .rst       (rst),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .pready    (pready),
    .prdata    (prdata),
    .pslverr   (pslverr),
    .resp      (resp),
    .respValid (respValid)
  );

  always #50 clk = ~clk;

  //****************************************
  // Checks and APB access
  //****************************************
  function automatic void checkValue(input string name, input int expected, input int actual);
    checks++;
    assert (expected == actual) else begin
      $display("** Error %s: expected %0d, actual %0d", name, expected, actual);
      errors++;
    end
  endfunction

  function automatic logic [31:0] lineAddr(input tag_t tag, input index_t idx);
    return {tag, idx, ByteSelBits'($urandom)};  // Any byte of the line
  endfunction

  // Sampled on the falling edge, away from the DUT's clock edge
  task automatic waitReady(input string name);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!pready && cycles < TimeoutCycles) begin
      @(negedge clk);
      cycles++;
    end
    if (!pready) begin
      $display("Timeout: pready never came during %s", name);
      timeouts++;
    end
  endtask

  task automatic apbTransfer(input string name, input logic write, input logic [31:0] addr,
                             input logic [31:0] data, output logic [31:0] rdata,
                             output logic err, output logic valid, output cacheResp_t got);
    @(posedge clk);
    psel    <= 1'b1;  // Setup cycle
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    waitReady(name);
    rdata = prdata;
    err   = pslverr;
    valid = respValid;
    got   = resp;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // One command, every response field compared with the model
  task automatic runCmd(input string name, input cmdOp_t op, input snoop_t snoopIn,
                        input tag_t tag, input index_t idx, output cacheResp_t got);
    cacheReq_t   req;
    cacheResp_t  exp;
    logic [31:0] rdata;
    logic        err;
    logic        valid;
    req.op      = op;
    req.snoopIn = snoopIn;
    apbTransfer(name, 1'b1, lineAddr(tag, idx), 32'(req), rdata, err, valid, got);
    checkValue({name, " pslverr"}, 0, err);
    checkValue({name, " respValid"}, 1, valid);
    if (op == Clear) begin
      resetModel();
      exp = '{hit: 1'b0, way: '0, newState: Invalid, busOp: BusNone, snoopOut: SnoopMiss};
    end else begin
      exp = predictAccess(op, snoopIn, tag, idx);
    end
    checkValue({name, " hit"}, exp.hit, got.hit);
    if (exp.hit || op inside {L1Read, L1InstRead, L1Write}) begin
      checkValue({name, " way"}, exp.way, got.way);
    end
    checkValue({name, " state"}, exp.newState, got.newState);
    checkValue({name, " bus op"}, exp.busOp, got.busOp);
    checkValue({name, " snoop out"}, exp.snoopOut, got.snoopOut);
  endtask

  task automatic checkCounters(input string name);
    int          expected [4];
    logic [31:0] rdata;
    logic        err;
    logic        valid;
    cacheResp_t  got;
    expected = '{refHits, refMisses, refReads, refWrites};
    for (int i = 0; i < 4; i++) begin
      apbTransfer(name, 1'b0, 32'(i << 2), '0, rdata, err, valid, got);
      checkValue($sformatf("%s counter %0d", name, i), expected[i], rdata);
      checkValue({name, " counter pslverr"}, 0, err);
    end
  endtask

  // Outputs stay quiet for the whole sweep that follows reset
  task automatic waitResetSweep();
    for (int c = 0; c < NumSets + 4; c++) begin
      @(negedge clk);
      checkValue("reset sweep pready", 0, pready);
      checkValue("reset sweep pslverr", 0, pslverr);
      checkValue("reset sweep respValid", 0, respValid);
    end
  endtask

  //****************************************
  // Scenarios
  //****************************************
  task automatic readMissThenHit(input index_t idx, input tag_t tag);
    cacheResp_t got;
    runCmd("read miss", L1Read, SnoopMiss, tag, idx, got);
    checkValue("read miss state", Exclusive, got.newState);
    checkValue("read miss bus op", BusRead, got.busOp);
    runCmd("read hit", L1Read, snoop_t'($urandom_range(2)), tag, idx, got);
    checkValue("read hit flag", 1, got.hit);
    checkValue("read hit bus op", BusNone, got.busOp);
    checkValue("read hit state", Exclusive, got.newState);
    runCmd("read shared", L1Read, SnoopHit, tag ^ tag_t'(1), idx, got);
    checkValue("read shared state", Shared, got.newState);
    runCmd("inst read shared", L1InstRead, SnoopHitM, tag ^ tag_t'(2), idx, got);
    checkValue("inst read shared state", Shared, got.newState);
  endtask

  task automatic writeUpgrades(input index_t idx);
    tag_t       tag;
    cacheResp_t got;
    tag = tag_t'($urandom);
    runCmd("write miss", L1Write, SnoopMiss, tag, idx, got);
    checkValue("write miss bus op", BusRfo, got.busOp);
    checkValue("write miss state", Modified, got.newState);
    runCmd("write on M", L1Write, SnoopMiss, tag, idx, got);
    checkValue("write on M bus op", BusNone, got.busOp);
    runCmd("fill S", L1Read, SnoopHit, tag ^ tag_t'(1), idx, got);
    runCmd("write on S", L1Write, SnoopMiss, tag ^ tag_t'(1), idx, got);
    checkValue("write on S bus op", BusInval, got.busOp);
    runCmd("fill E", L1Read, SnoopMiss, tag ^ tag_t'(2), idx, got);
    runCmd("write on E", L1Write, SnoopMiss, tag ^ tag_t'(2), idx, got);
    checkValue("write on E bus op", BusInval, got.busOp);
    checkValue("write on E state", Modified, got.newState);
  endtask

  task automatic snoopResponses(input index_t idx);
    tag_t       tm;
    tag_t       te;
    tag_t       ts;
    tag_t       tx;
    cacheResp_t got;
    tm = tag_t'($urandom);
    te = tm ^ tag_t'(1);
    ts = tm ^ tag_t'(2);
    tx = tm ^ tag_t'(3);
    runCmd("fill M", L1Write, SnoopMiss, tm, idx, got);
    runCmd("fill E", L1Read, SnoopMiss, te, idx, got);
    runCmd("fill S", L1Read, SnoopHit, ts, idx, got);
    runCmd("snoop read M", SnoopRead, SnoopMiss, tm, idx, got);
    checkValue("snoop read M answer", SnoopHitM, got.snoopOut);
    checkValue("snoop read M state", Shared, got.newState);
    runCmd("snoop read E", SnoopRead, SnoopMiss, te, idx, got);
    checkValue("snoop read E answer", SnoopHit, got.snoopOut);
    runCmd("snoop read S", SnoopRead, SnoopMiss, ts, idx, got);
    checkValue("snoop read S answer", SnoopHit, got.snoopOut);
    runCmd("snoop read miss", SnoopRead, SnoopMiss, tx, idx, got);
    checkValue("snoop read miss answer", SnoopMiss, got.snoopOut);
    runCmd("upgrade", L1Write, SnoopMiss, tm, idx, got);
    runCmd("snoop inval M", SnoopInval, SnoopMiss, tm, idx, got);
    checkValue("snoop inval M answer", SnoopHitM, got.snoopOut);
    runCmd("snoop rfo S", SnoopRfo, SnoopMiss, te, idx, got);
    checkValue("snoop rfo S answer", SnoopHit, got.snoopOut);
    runCmd("fill M again", L1Write, SnoopMiss, tx, idx, got);
    runCmd("snoop rfo M", SnoopRfo, SnoopMiss, tx, idx, got);
    checkValue("snoop rfo M answer", SnoopHitM, got.snoopOut);
    runCmd("read after inval", L1Read, SnoopMiss, tm, idx, got);
    checkValue("read after inval hit", 0, got.hit);
    runCmd("read after rfo", L1Read, SnoopMiss, te, idx, got);
    checkValue("read after rfo hit", 0, got.hit);
  endtask

  // Fill a fresh set in way order, re-touch one line, then evict
  task automatic lruReplacement(input index_t idx);
    tag_t       tags [5];
    tag_t       high;
    int         j;
    int         victim;
    cacheResp_t got;
    high = tag_t'($urandom);
    for (int i = 0; i < 5; i++) begin
      tags[i] = {high[TagBits-1:3], 3'(i)};
    end
    for (int i = 0; i < 4; i++) begin
      runCmd("lru fill", L1Read, snoop_t'($urandom_range(2)), tags[i], idx, got);
    end
    j = $urandom_range(3);
    // Fills leave way 0 oldest, a touch on way 0 hands that to way 1
    victim = (j == 0) ? 1 : 0;
    runCmd("lru touch", L1Write, SnoopMiss, tags[j], idx, got);
    checkValue("lru touch hit", 1, got.hit);
    runCmd("lru evict", L1Read, SnoopMiss, tags[4], idx, got);
    checkValue("lru evict hit", 0, got.hit);
    checkValue("lru evict way", victim, got.way);
    runCmd("lru evicted tag", L1Read, SnoopMiss, tags[victim], idx, got);
    checkValue("lru evicted tag hit", 0, got.hit);
  endtask

  task automatic unknownOpRejected(input index_t idx, input tag_t tag);
    cacheReq_t   req;
    cacheResp_t  got;
    logic [31:0] rdata;
    logic        err;
    logic        valid;
    checkCounters("before unknown op");
    req.op      = cmdOp_t'(3'd5);  // No command has this code
    req.snoopIn = SnoopMiss;
    apbTransfer("unknown op", 1'b1, lineAddr(tag, idx), 32'(req), rdata, err, valid, got);
    checkValue("unknown op pslverr", 1, err);
    checkValue("unknown op respValid", 1, valid);
    checkCounters("after unknown op");
    runCmd("read after unknown op", L1Read, SnoopMiss, tag, idx, got);
  endtask

  task automatic randomTraffic(input index_t firstIdx, input int count);
    tag_t       base;
    cmdOp_t     op;
    index_t     idx;
    cacheResp_t got;
    base = tag_t'($urandom);
    for (int n = 0; n < count; n++) begin
      case ($urandom_range(5))
        0:       op = L1Read;
        1:       op = L1InstRead;
        2:       op = L1Write;
        3:       op = SnoopRead;
        4:       op = SnoopInval;
        default: op = SnoopRfo;
      endcase
      idx = index_t'(firstIdx + $urandom_range(1));
      // Six tags over four ways keeps evictions coming
      runCmd("random", op, snoop_t'($urandom_range(2)), base ^ tag_t'($urandom_range(5)),
             idx, got);
    end
  endtask

  task automatic clearEmptiesCache();
    tag_t       tags [$];
    index_t     sets [$];
    cacheResp_t got;
    for (int s = 0; s < NumSets; s++) begin
      for (int w = 0; w < NumWays; w++) begin
        if (refState[s][w] != Invalid) begin
          tags.push_back(refTag[s][w]);
          sets.push_back(index_t'(s));
        end
      end
    end
    runCmd("clear", Clear, SnoopMiss, '0, '0, got);
    foreach (tags[i]) begin
      runCmd("read after clear", L1Read, SnoopMiss, tags[i], sets[i], got);
      checkValue("read after clear hit", 0, got.hit);
    end
  endtask

  //****************************************
  // Main sequence
  //****************************************
  initial begin
    void'($urandom(32'h7061_3fbf));
    clk       = 1'b0;
    rst       = 1'b1;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    errors    = 0;
    checks    = 0;
    timeouts  = 0;
    refHits   = 0;
    refMisses = 0;
    refReads  = 0;
    refWrites = 0;
    resetModel();
    baseIdx = index_t'($urandom);
    keepTag = tag_t'($urandom);
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    waitResetSweep();

    readMissThenHit(baseIdx, keepTag);
    writeUpgrades(index_t'(baseIdx + 1));
    snoopResponses(index_t'(baseIdx + 2));
    lruReplacement(index_t'(baseIdx + 3));
    unknownOpRejected(baseIdx, keepTag);
    randomTraffic(index_t'(baseIdx + 4), 60);
    checkCounters("after random traffic");
    clearEmptiesCache();
    checkCounters("after clear");  // Clear leaves the statistics alone

    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+tb
logic/l2CachePkg.sv
logic/tagStore.sv
logic/wayLookup.sv
logic/mesiPolicy.sv
logic/statCounters.sv
logic/apbCmdPort.sv
logic/l2Cache.sv
tb/l2CacheTb.sv

/* run.sh */
#!/bin/sh
# Build the L2 cache testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module l2CacheTb -f verilog.f -o l2CacheSim

out=$(./obj_dir/l2CacheSim)
echo "$out"

if echo "$out" | grep -qx "TEST PASSED"; then
  exit 0
fi
exit 1
